/* verilog/trigger_xbar_pkg.sv */
package trigger_xbar_pkg;

	// sizes of the crossbar
	localparam int N_INPUTS = 6;
	localparam int N_OUTPUTS = 9;
	localparam int N_EXTERNAL = 4;
	localparam int N_LINKS = 16;
	localparam int N_REG = 64;

	// field widths
	localparam int WORD_W = 8;
	localparam int SEL_W = 4;
	localparam int ADDR_W = $clog2(N_REG);
	localparam int SLOT_W = $clog2(N_LINKS);
	localparam int DATA_W = 32;

	// bit 0 is the earliest sample
	typedef logic [WORD_W-1:0] trig_word_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] reg_data_t;

	// version 1.0.0
	localparam reg_data_t BLOCK_VERSION = 32'h0001_0000;

	// register map
	localparam reg_addr_t ADDR_OUT_BASE = 6'd0;
	localparam reg_addr_t ADDR_IN_BASE = 6'd16;
	localparam reg_addr_t ADDR_OEB = 6'd32;
	localparam reg_addr_t ADDR_N_INPUTS = 6'd33;
	localparam reg_addr_t ADDR_N_OUTPUTS = 6'd34;
	localparam reg_addr_t ADDR_N_EXTERNAL = 6'd35;
	localparam reg_addr_t ADDR_VERSION = 6'd63;

	// fields of a link register, select sits in the low bits
	localparam int BIT_DIR = 8;
	localparam int BIT_FORCE_EN = 16;
	localparam int BIT_FORCE_VAL = 17;
	localparam int BIT_CURRENT = 24;

	// reset values, select table indexed by output slot
	localparam sel_t DEFAULT_SELECT [N_LINKS] = '{
		4'd5, 4'd5, 4'd5, 4'd5, 4'd5, 4'd1, 4'd2, 4'd3,
		4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0
	};
	localparam logic DEFAULT_DIR = 1'b1;
	localparam logic DEFAULT_OEB = 1'b1;

endpackage

/* verilog/trigger_config_regs.sv */
module trigger_config_regs (
	input  logic                                      clk160,
	input  logic                                      rst,
	input  logic                                      reg_wr,
	input  logic                                      reg_rd,
	input  trigger_xbar_pkg::reg_addr_t               reg_addr,
	input  trigger_xbar_pkg::reg_data_t               reg_wdata,
	input  logic [trigger_xbar_pkg::N_INPUTS-1:0]     in_current,
	input  logic [trigger_xbar_pkg::N_OUTPUTS-1:0]    out_current,
	output trigger_xbar_pkg::reg_data_t               reg_rdata,
	output logic                                      reg_rack,
	output logic [trigger_xbar_pkg::N_OUTPUTS*trigger_xbar_pkg::SEL_W-1:0] out_select,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]    out_force_en,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]    out_force_val,
	output logic [trigger_xbar_pkg::N_INPUTS-1:0]     in_force_en,
	output logic [trigger_xbar_pkg::N_INPUTS-1:0]     in_force_val,
	output logic [trigger_xbar_pkg::N_EXTERNAL-1:0]   trigger_dirs,
	output logic                                      output_enable_bar
);

	// writable fields of every slot
	trigger_xbar_pkg::sel_t out_sel_q [trigger_xbar_pkg::N_LINKS];
	logic [trigger_xbar_pkg::N_LINKS-1:0] out_dir_q;
	logic [trigger_xbar_pkg::N_LINKS-1:0] out_fen_q;
	logic [trigger_xbar_pkg::N_LINKS-1:0] out_fval_q;
	logic [trigger_xbar_pkg::N_LINKS-1:0] in_fen_q;
	logic [trigger_xbar_pkg::N_LINKS-1:0] in_fval_q;
	logic oeb_q;

	// live levels padded out to a full link group
	logic [trigger_xbar_pkg::N_LINKS-1:0] in_cur_ext;
	logic [trigger_xbar_pkg::N_LINKS-1:0] out_cur_ext;

	logic [trigger_xbar_pkg::SLOT_W-1:0] slot;
	logic out_hit;
	logic in_hit;
	trigger_xbar_pkg::reg_data_t rd_word;

	assign slot = reg_addr[trigger_xbar_pkg::SLOT_W-1:0];
	assign out_hit = reg_addr[trigger_xbar_pkg::ADDR_W-1:trigger_xbar_pkg::SLOT_W] ==
		trigger_xbar_pkg::ADDR_OUT_BASE[trigger_xbar_pkg::ADDR_W-1:trigger_xbar_pkg::SLOT_W];
	assign in_hit = reg_addr[trigger_xbar_pkg::ADDR_W-1:trigger_xbar_pkg::SLOT_W] ==
		trigger_xbar_pkg::ADDR_IN_BASE[trigger_xbar_pkg::ADDR_W-1:trigger_xbar_pkg::SLOT_W];

	assign in_cur_ext = trigger_xbar_pkg::N_LINKS'(in_current);
	assign out_cur_ext = trigger_xbar_pkg::N_LINKS'(out_current);

	// write decode, read-only bits are simply not stored
	always_ff @(posedge clk160) begin
		if (rst) begin
			for (int i = 0; i < trigger_xbar_pkg::N_LINKS; i++) begin
				out_sel_q[i] <= trigger_xbar_pkg::DEFAULT_SELECT[i];
			end
			out_dir_q <= {trigger_xbar_pkg::N_LINKS{trigger_xbar_pkg::DEFAULT_DIR}};
			out_fen_q <= '0;
			out_fval_q <= '0;
			in_fen_q <= '0;
			in_fval_q <= '0;
			oeb_q <= trigger_xbar_pkg::DEFAULT_OEB;
		end else if (reg_wr) begin
			if (out_hit) begin
				out_sel_q[slot] <= reg_wdata[trigger_xbar_pkg::SEL_W-1:0];
				out_dir_q[slot] <= reg_wdata[trigger_xbar_pkg::BIT_DIR];
				out_fen_q[slot] <= reg_wdata[trigger_xbar_pkg::BIT_FORCE_EN];
				out_fval_q[slot] <= reg_wdata[trigger_xbar_pkg::BIT_FORCE_VAL];
			end else if (in_hit) begin
				in_fen_q[slot] <= reg_wdata[trigger_xbar_pkg::BIT_FORCE_EN];
				in_fval_q[slot] <= reg_wdata[trigger_xbar_pkg::BIT_FORCE_VAL];
			end else if (reg_addr == trigger_xbar_pkg::ADDR_OEB) begin
				oeb_q <= reg_wdata[0];
			end
		end
	end

	// read mux, slots past the real counts read as zero
	always_comb begin
		rd_word = '0;
		if (out_hit) begin
			if (slot < trigger_xbar_pkg::N_OUTPUTS) begin
				rd_word[trigger_xbar_pkg::SEL_W-1:0] = out_sel_q[slot];
				rd_word[trigger_xbar_pkg::BIT_DIR] = out_dir_q[slot];
				rd_word[trigger_xbar_pkg::BIT_FORCE_EN] = out_fen_q[slot];
				rd_word[trigger_xbar_pkg::BIT_FORCE_VAL] = out_fval_q[slot];
				rd_word[trigger_xbar_pkg::BIT_CURRENT] = out_cur_ext[slot];
			end
		end else if (in_hit) begin
			if (slot < trigger_xbar_pkg::N_INPUTS) begin
				rd_word[trigger_xbar_pkg::BIT_FORCE_EN] = in_fen_q[slot];
				rd_word[trigger_xbar_pkg::BIT_FORCE_VAL] = in_fval_q[slot];
				rd_word[trigger_xbar_pkg::BIT_CURRENT] = in_cur_ext[slot];
			end
		end else begin
			case (reg_addr)
				trigger_xbar_pkg::ADDR_OEB: rd_word[0] = oeb_q;
				trigger_xbar_pkg::ADDR_N_INPUTS:
					rd_word = trigger_xbar_pkg::DATA_W'(trigger_xbar_pkg::N_INPUTS);
				trigger_xbar_pkg::ADDR_N_OUTPUTS:
					rd_word = trigger_xbar_pkg::DATA_W'(trigger_xbar_pkg::N_OUTPUTS);
				trigger_xbar_pkg::ADDR_N_EXTERNAL:
					rd_word = trigger_xbar_pkg::DATA_W'(trigger_xbar_pkg::N_EXTERNAL);
				trigger_xbar_pkg::ADDR_VERSION: rd_word = trigger_xbar_pkg::BLOCK_VERSION;
				default: rd_word = '0;
			endcase
		end
	end

	// answer one cycle after the strobe
	always_ff @(posedge clk160) begin
		if (rst) begin
			reg_rack <= 1'b0;
		end else begin
			reg_rack <= reg_rd;
		end
	end

	always_ff @(posedge clk160) begin
		if (reg_rd) begin
			reg_rdata <= rd_word;
		end
	end

	// fan out the fields that drive real links
	always_comb begin
		for (int i = 0; i < trigger_xbar_pkg::N_OUTPUTS; i++) begin
			out_select[i*trigger_xbar_pkg::SEL_W +: trigger_xbar_pkg::SEL_W] = out_sel_q[i];
		end
	end

	assign out_force_en = out_fen_q[trigger_xbar_pkg::N_OUTPUTS-1:0];
	assign out_force_val = out_fval_q[trigger_xbar_pkg::N_OUTPUTS-1:0];
	assign in_force_en = in_fen_q[trigger_xbar_pkg::N_INPUTS-1:0];
	assign in_force_val = in_fval_q[trigger_xbar_pkg::N_INPUTS-1:0];
	assign trigger_dirs = out_dir_q[trigger_xbar_pkg::N_EXTERNAL-1:0];
	assign output_enable_bar = oeb_q;

endmodule

/* verilog/trigger_input_stage.sv */
module trigger_input_stage (
	input  logic                                   clk160,
	input  logic                                   rst,
	input  logic [trigger_xbar_pkg::N_INPUTS*trigger_xbar_pkg::WORD_W-1:0] trigger_words,
	input  logic [trigger_xbar_pkg::N_INPUTS-1:0]  in_force_en,
	input  logic [trigger_xbar_pkg::N_INPUTS-1:0]  in_force_val,
	output logic [trigger_xbar_pkg::N_INPUTS*trigger_xbar_pkg::WORD_W-1:0] in_words,
	output logic [trigger_xbar_pkg::N_INPUTS-1:0]  in_current
);

	trigger_xbar_pkg::trig_word_t next_word [trigger_xbar_pkg::N_INPUTS];

	// forced input holds its level over the whole word
	always_comb begin
		for (int i = 0; i < trigger_xbar_pkg::N_INPUTS; i++) begin
			if (in_force_en[i]) begin
				next_word[i] = {trigger_xbar_pkg::WORD_W{in_force_val[i]}};
			end else begin
				next_word[i] = trigger_words[i*trigger_xbar_pkg::WORD_W +: trigger_xbar_pkg::WORD_W];
			end
		end
	end

	// one capture stage for every source
	always_ff @(posedge clk160) begin
		if (rst) begin
			in_words <= '0;
		end else begin
			for (int i = 0; i < trigger_xbar_pkg::N_INPUTS; i++) begin
				in_words[i*trigger_xbar_pkg::WORD_W +: trigger_xbar_pkg::WORD_W] <= next_word[i];
			end
		end
	end

	// earliest sample of each word is the reported level
	always_comb begin
		for (int i = 0; i < trigger_xbar_pkg::N_INPUTS; i++) begin
			in_current[i] = in_words[i*trigger_xbar_pkg::WORD_W];
		end
	end

endmodule

/* verilog/trigger_output_mux.sv */
module trigger_output_mux (
	input  logic                                    clk160,
	input  logic                                    rst,
	input  logic [trigger_xbar_pkg::N_INPUTS*trigger_xbar_pkg::WORD_W-1:0] in_words,
	input  logic [trigger_xbar_pkg::N_OUTPUTS*trigger_xbar_pkg::SEL_W-1:0] out_select,
	input  logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  out_force_en,
	input  logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  out_force_val,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  trigger_outputs,
	output logic [trigger_xbar_pkg::N_OUTPUTS*trigger_xbar_pkg::WORD_W-1:0] stream_data,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  stream_valid,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  out_current
);

	trigger_xbar_pkg::trig_word_t pick [trigger_xbar_pkg::N_OUTPUTS];
	logic valid_q;

	// source select per output, force wins over select
	always_comb begin
		trigger_xbar_pkg::sel_t sel;
		for (int o = 0; o < trigger_xbar_pkg::N_OUTPUTS; o++) begin
			sel = out_select[o*trigger_xbar_pkg::SEL_W +: trigger_xbar_pkg::SEL_W];
			if (out_force_en[o]) begin
				pick[o] = {trigger_xbar_pkg::WORD_W{out_force_val[o]}};
			end else if (sel < trigger_xbar_pkg::N_INPUTS) begin
				pick[o] = in_words[sel*trigger_xbar_pkg::WORD_W +: trigger_xbar_pkg::WORD_W];
			end else begin
				// no such source
				pick[o] = '0;
			end
		end
	end

	// level and stream leave through the same register
	always_ff @(posedge clk160) begin
		if (rst) begin
			trigger_outputs <= '0;
			stream_data <= '0;
		end else begin
			for (int o = 0; o < trigger_xbar_pkg::N_OUTPUTS; o++) begin
				trigger_outputs[o] <= pick[o][0];
				stream_data[o*trigger_xbar_pkg::WORD_W +: trigger_xbar_pkg::WORD_W] <= pick[o];
			end
		end
	end

	// streams never stall, valid from the first edge out of reset
	always_ff @(posedge clk160) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b1;
		end
	end

	assign stream_valid = {trigger_xbar_pkg::N_OUTPUTS{valid_q}};
	assign out_current = trigger_outputs;

endmodule

/* verilog/trigger_xbar.sv */
module trigger_xbar (
	input  logic                                    clk160,
	input  logic                                    rst,
	input  logic [trigger_xbar_pkg::N_INPUTS*trigger_xbar_pkg::WORD_W-1:0] trigger_words,
	input  logic                                    reg_wr,
	input  logic                                    reg_rd,
	input  trigger_xbar_pkg::reg_addr_t             reg_addr,
	input  trigger_xbar_pkg::reg_data_t             reg_wdata,
	output trigger_xbar_pkg::reg_data_t             reg_rdata,
	output logic                                    reg_rack,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  trigger_outputs,
	output logic [trigger_xbar_pkg::N_OUTPUTS*trigger_xbar_pkg::WORD_W-1:0] stream_data,
	output logic [trigger_xbar_pkg::N_OUTPUTS-1:0]  stream_valid,
	output logic [trigger_xbar_pkg::N_EXTERNAL-1:0] trigger_dirs,
	output logic                                    output_enable_bar
);

	// configuration to the datapath
	logic [trigger_xbar_pkg::N_OUTPUTS*trigger_xbar_pkg::SEL_W-1:0] out_select;
	logic [trigger_xbar_pkg::N_OUTPUTS-1:0] out_force_en;
	logic [trigger_xbar_pkg::N_OUTPUTS-1:0] out_force_val;
	logic [trigger_xbar_pkg::N_INPUTS-1:0] in_force_en;
	logic [trigger_xbar_pkg::N_INPUTS-1:0] in_force_val;

	// datapath and status back to the registers
	logic [trigger_xbar_pkg::N_INPUTS*trigger_xbar_pkg::WORD_W-1:0] in_words;
	logic [trigger_xbar_pkg::N_INPUTS-1:0] in_current;
	logic [trigger_xbar_pkg::N_OUTPUTS-1:0] out_current;

	trigger_config_regs config_regs_inst (
		.clk160(clk160),
		.rst(rst),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.in_current(in_current),
		.out_current(out_current),
		.reg_rdata(reg_rdata),
		.reg_rack(reg_rack),
		.out_select(out_select),
		.out_force_en(out_force_en),
		.out_force_val(out_force_val),
		.in_force_en(in_force_en),
		.in_force_val(in_force_val),
		.trigger_dirs(trigger_dirs),
		.output_enable_bar(output_enable_bar)
	);

	trigger_input_stage input_stage_inst (
		.clk160(clk160),
		.rst(rst),
		.trigger_words(trigger_words),
		.in_force_en(in_force_en),
		.in_force_val(in_force_val),
		.in_words(in_words),
		.in_current(in_current)
	);

	trigger_output_mux output_mux_inst (
		.clk160(clk160),
		.rst(rst),
		.in_words(in_words),
		.out_select(out_select),
		.out_force_en(out_force_en),
		.out_force_val(out_force_val),
		.trigger_outputs(trigger_outputs),
		.stream_data(stream_data),
		.stream_valid(stream_valid),
		.out_current(out_current)
	);

endmodule

/* test/trigger_xbar_tb.sv */
module trigger_xbar_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk160 = 1'b0;
	logic rst;
	logic [47:0] trigger_words;
	logic reg_wr;
	logic reg_rd;
	logic [5:0] reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic reg_rack;
	logic [8:0] trigger_outputs;
	logic [71:0] stream_data;
	logic [8:0] stream_valid;
	logic [3:0] trigger_dirs;
	logic output_enable_bar;

	// reference model of the register fields and the two pipeline stages
	logic [3:0] m_sel [16];
	logic [15:0] m_dir;
	logic [15:0] m_ofen;
	logic [15:0] m_ofval;
	logic [15:0] m_ifen;
	logic [15:0] m_ifval;
	logic m_oeb;
	logic [7:0] m_in [6];
	logic [7:0] m_out [9];

	integer seed = 32'h7719_d36a;
	int cycles = 0;
	int fail_count = 0;
	string test_name = "reset";
	logic [31:0] rnd;
	logic [31:0] wd;

	trigger_xbar trigger_xbar_inst (.*);

	always #4 clk160 = ~clk160;

	task automatic report_failure(input string what);
		fail_count++;
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string label, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			report_failure($sformatf("Fail %s %s expected %h actual %h",
				test_name, label, exp, act));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk160);
		#1;
	endtask

	task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
		reg_addr = addr;
		reg_wdata = data;
		reg_wr = 1'b1;
		next_cycle();
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input logic [5:0] addr, output logic [31:0] data);
		int waited;
		waited = 0;
		reg_addr = addr;
		reg_rd = 1'b1;
		next_cycle();
		reg_rd = 1'b0;
		while (reg_rack !== 1'b1 && waited < 4) begin
			next_cycle();
			waited++;
		end
		if (reg_rack !== 1'b1) begin
			report_failure($sformatf("register read of address %0d got no reg_rack", addr));
		end else begin
			data = reg_rdata;
		end
	endtask

	task automatic read_expect(input logic [5:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		reg_read(addr, data);
		check_value($sformatf("read %0d", addr), exp, data);
	endtask

	// outputs 5 to 7 follow sources 1 to 3 after reset
	function automatic logic [3:0] default_select(input int slot);
		if (slot < 5) return 4'd5;
		if (slot < 8) return 4'(slot - 4);
		return 4'd0;
	endfunction

	function automatic logic [7:0] route(input int o);
		int src;
		src = int'(m_sel[o]);
		if (m_ofen[o]) return {8{m_ofval[o]}};
		if (src < 6) return m_in[src];
		return 8'h00;
	endfunction

	// readback as seen just before the edge that takes the read strobe
	function automatic logic [31:0] expected_read(input logic [5:0] addr);
		logic [31:0] w;
		int s;
		w = '0;
		s = int'(addr[3:0]);
		if (addr < 6'd16) begin
			if (s < 9) begin
				w[3:0] = m_sel[s];
				w[8] = m_dir[s];
				w[16] = m_ofen[s];
				w[17] = m_ofval[s];
				w[24] = m_out[s][0];
			end
		end else if (addr < 6'd32) begin
			if (s < 6) begin
				w[16] = m_ifen[s];
				w[17] = m_ifval[s];
				w[24] = m_in[s][0];
			end
		end else if (addr == 6'd32) begin
			w[0] = m_oeb;
		end else if (addr == 6'd33) begin
			w = 32'd6;
		end else if (addr == 6'd34) begin
			w = 32'd9;
		end else if (addr == 6'd35) begin
			w = 32'd4;
		end else if (addr == 6'd63) begin
			w = 32'h0001_0000;
		end
		return w;
	endfunction

	task automatic read_check(input logic [5:0] addr);
		read_expect(addr, expected_read(addr));
	endtask

	always @(posedge clk160) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				m_sel[i] <= default_select(i);
			end
			m_dir <= '1;
			m_ofen <= '0;
			m_ofval <= '0;
			m_ifen <= '0;
			m_ifval <= '0;
			m_oeb <= 1'b1;
			for (int i = 0; i < 6; i++) begin
				m_in[i] <= '0;
			end
			for (int o = 0; o < 9; o++) begin
				m_out[o] <= '0;
			end
		end else begin
			if (reg_wr && reg_addr < 6'd16) begin
				m_sel[reg_addr[3:0]] <= reg_wdata[3:0];
				m_dir[reg_addr[3:0]] <= reg_wdata[8];
				m_ofen[reg_addr[3:0]] <= reg_wdata[16];
				m_ofval[reg_addr[3:0]] <= reg_wdata[17];
			end else if (reg_wr && reg_addr < 6'd32) begin
				m_ifen[reg_addr[3:0]] <= reg_wdata[16];
				m_ifval[reg_addr[3:0]] <= reg_wdata[17];
			end else if (reg_wr && reg_addr == 6'd32) begin
				m_oeb <= reg_wdata[0];
			end
			for (int i = 0; i < 6; i++) begin
				m_in[i] <= m_ifen[i] ? {8{m_ifval[i]}} : trigger_words[i*8 +: 8];
			end
			for (int o = 0; o < 9; o++) begin
				m_out[o] <= route(o);
			end
		end
	end

	// outputs compared mid-cycle away from the edges
	always @(negedge clk160) begin
		if (!rst) begin
			for (int o = 0; o < 9; o++) begin
				check_value($sformatf("stream %0d", o), 32'(m_out[o]),
					32'(stream_data[o*8 +: 8]));
				check_value($sformatf("level %0d", o), 32'(m_out[o][0]),
					32'(trigger_outputs[o]));
			end
			check_value("dir pins", 32'(m_dir[3:0]), 32'(trigger_dirs));
			check_value("oeb pin", 32'(m_oeb), 32'(output_enable_bar));
		end
	end

	assert property (@(posedge clk160) disable iff (rst) reg_rack == $past(reg_rd))
		else report_failure("reg_rack was not a single cycle answer to reg_rd");
	assert property (@(posedge clk160) !rst |=> &stream_valid)
		else report_failure("stream_valid was low after reset");

	// new random samples every cycle
	always @(posedge clk160) begin
		#1;
		trigger_words[31:0] = $random(seed);
		trigger_words[47:32] = 16'($random(seed));
	end

	always @(posedge clk160) begin
		cycles++;
		if (cycles == 3000) begin
			report_failure("timeout, the test sequence did not finish within 3000 cycles");
		end
	end

	initial begin
		rst = 1'b1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		trigger_words = '0;
		repeat (5) @(posedge clk160);
		#1;
		rst = 1'b0;

		check_value("oeb after reset", 32'd1, 32'(output_enable_bar));
		check_value("dirs after reset", 32'hf, 32'(trigger_dirs));
		for (int a = 0; a <= 32; a++) begin
			read_check(6'(a));
		end
		read_expect(6'd33, 32'd6);
		read_expect(6'd34, 32'd9);
		read_expect(6'd35, 32'd4);
		read_expect(6'd63, 32'h0001_0000);
		check_value("stream_valid", 32'h1ff, 32'(stream_valid));

		// random reroutes with the read-only current bit sometimes set
		test_name = "routing";
		repeat (400) begin
			rnd = $random(seed);
			wd = '0;
			wd[3:0] = 4'(int'(rnd[11:8]) % 6);
			wd[8] = 1'b1;
			wd[24] = rnd[15];
			reg_write(6'(int'(rnd[7:0]) % 9), wd);
			repeat (int'(rnd[14:13])) next_cycle();
			read_check(6'(int'(rnd[7:0]) % 9));
		end

		test_name = "out of range";
		for (int pass = 0; pass < 2; pass++) begin
			for (int o = 0; o < 9; o++) begin
				reg_write(6'(o), (pass == 0 ? 32'(6 + o) : 32'(15 - o)) | 32'h100);
			end
			repeat (3) next_cycle();
			check_value("levels", 32'd0, 32'(trigger_outputs));
			check_value("stream low", 32'd0, stream_data[31:0]);
			check_value("stream mid", 32'd0, stream_data[63:32]);
			check_value("stream high", 32'd0, 32'(stream_data[71:64]));
		end

		test_name = "forcing";
		for (int o = 0; o < 9; o++) begin
			reg_write(6'(o), 32'(o % 6) | 32'h100);
		end
		for (int i = 0; i < 6; i++) begin
			reg_write(6'(16 + i), 32'h0001_0000 | (32'(i % 2) << 17));
		end
		repeat (3) next_cycle();
		for (int o = 0; o < 9; o++) begin
			check_value("input forced", (o % 6) % 2 == 1 ? 32'hff : 32'h0,
				32'(stream_data[o*8 +: 8]));
		end
		for (int i = 0; i < 6; i++) begin
			read_expect(6'(16 + i), 32'h0001_0000 | (i % 2 == 1 ? 32'h0102_0000 : 32'h0));
		end
		// output force on top at the opposite level
		for (int o = 0; o < 9; o++) begin
			reg_write(6'(o), 32'(o % 6) | 32'h0001_0100 | (32'((o + 1) % 2) << 17));
		end
		for (int i = 0; i < 6; i++) begin
			reg_write(6'(16 + i), 32'h0);
		end
		repeat (3) next_cycle();
		for (int o = 0; o < 9; o++) begin
			check_value("output forced", o % 2 == 0 ? 32'hff : 32'h0,
				32'(stream_data[o*8 +: 8]));
			read_expect(6'(o), 32'(o % 6) | 32'h0001_0100 |
				(o % 2 == 0 ? 32'h0102_0000 : 32'h0));
		end
		for (int o = 0; o < 9; o++) begin
			reg_write(6'(o), 32'(o % 6) | 32'h100);
		end

		test_name = "read only";
		for (int o = 0; o < 4; o++) begin
			reg_write(6'(o), 32'(o % 6));
			check_value("dir pins", (32'hf << (o + 1)) & 32'hf, 32'(trigger_dirs));
		end
		reg_write(6'd32, 32'h0);
		check_value("oeb cleared", 32'd0, 32'(output_enable_bar));
		read_check(6'd32);
		reg_write(6'd22, 32'hffff_ffff);
		reg_write(6'd12, 32'hffff_ffff);
		read_check(6'd22);
		read_check(6'd12);
		for (int a = 33; a < 64; a++) begin
			reg_write(6'(a), 32'hffff_ffff);
		end
		for (int a = 33; a < 64; a++) begin
			read_check(6'(a));
		end

		next_cycle();
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
verilog/trigger_xbar_pkg.sv
verilog/trigger_config_regs.sv
verilog/trigger_input_stage.sv
verilog/trigger_output_mux.sv
verilog/trigger_xbar.sv
test/trigger_xbar_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module trigger_xbar_tb -o trigger_xbar_sim

# the simulation result is judged from the log below
./obj_dir/trigger_xbar_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
